// ==== Makefile ====
VERILATOR  := verilator
TOP        := sound_tb
LINT_TOP   := sound_top
FILELIST   := sound_top.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sound_top.f ====
src/sound_pkg.sv
src/sound_apb_regs.sv
src/sound_bonus_voice.sv
src/sound_crash_voice.sv
src/sound_output_stage.sv
src/sound_top.sv
verif/sound_props.sv
verif/sound_tb.sv

// ==== src/sound_apb_regs.sv ====
`timescale 1ns/1ps

module sound_apb_regs (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [sound_pkg::ADDR_W-1:0]  paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pslverr,
	input  logic                          bonus_busy,
	input  logic                          crash_busy,
	output logic                          bonus_en,
	output logic                          crash_trig,
	output logic [7:0]                    bonus_gain,
	output logic [7:0]                    crash_gain
);
	logic setup_phase;
	logic access_wr;
	logic hit_ctrl;
	logic hit_volume;
	logic hit_status;
	logic mapped;
	logic err_next;
	logic [31:0] rdata_mux;

	assign setup_phase = psel && !penable;
	assign access_wr   = psel && penable && pwrite;

	assign hit_ctrl   = (paddr == sound_pkg::ADDR_CTRL);
	assign hit_volume = (paddr == sound_pkg::ADDR_VOLUME);
	assign hit_status = (paddr == sound_pkg::ADDR_STATUS);
	assign mapped     = hit_ctrl || hit_volume || hit_status;

	// STATUS is read-only, so a write to it is an error as well
	assign err_next = !mapped || (pwrite && hit_status);

	always_comb begin
		rdata_mux = '0;
		if (hit_ctrl) begin
			rdata_mux[0] = bonus_en; // Trigger bit always reads 0
		end else if (hit_volume) begin
			rdata_mux[15:0] = {crash_gain, bonus_gain};
		end else if (hit_status) begin
			rdata_mux[1:0] = {crash_busy, bonus_busy};
		end
	end

	// Read data and error are sampled in setup so they hold through the access cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (setup_phase) begin
			prdata  <= pwrite ? '0 : rdata_mux;
			pslverr <= err_next;
		end else begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bonus_en   <= 1'b0;
			crash_trig <= 1'b0;
			bonus_gain <= '0;
			crash_gain <= '0;
		end else begin
			crash_trig <= access_wr && hit_ctrl && pwdata[1]; // One-cycle pulse
			if (access_wr && hit_ctrl) begin
				bonus_en <= pwdata[0];
			end
			if (access_wr && hit_volume) begin
				bonus_gain <= pwdata[7:0];
				crash_gain <= pwdata[15:8];
			end
		end
	end

endmodule

// ==== src/sound_bonus_voice.sv ====
`timescale 1ns/1ps

module sound_bonus_voice (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            sample_tick,
	input  logic                            bonus_en,
	output logic [sound_pkg::SAMPLE_W-1:0]  bonus_sample,
	output logic                            bonus_busy
);
	localparam int PHASE_W  = $clog2(sound_pkg::SLOW_PERIOD);
	localparam int PCNT_W   = $clog2(sound_pkg::CYCLE_PERIODS);
	localparam int TAIL_LEN = sound_pkg::TAIL_PERIODS * sound_pkg::SLOW_PERIOD;
	localparam int TAIL_W   = $clog2(TAIL_LEN);
	localparam int MAP_FRAC = 16;
	localparam logic [MAP_FRAC-1:0] MAP_RATIO =
		MAP_FRAC'((sound_pkg::FAST_PERIOD << MAP_FRAC) / sound_pkg::SLOW_PERIOD);

	logic [sound_pkg::AMP_W-1:0] amp;
	logic [PHASE_W-1:0]          phase;
	logic [PCNT_W-1:0]           period_cnt;
	logic [TAIL_W-1:0]           tail_cnt;
	logic                        cycling;

	logic                        fast_wave;
	logic [PHASE_W-1:0]          period_last;
	logic [PHASE_W-1:0]          high_len;
	logic [1:0]                  level;
	logic [sound_pkg::AMP_W-1:0] wave_prod;
	logic [sound_pkg::AMP_W+sound_pkg::AMP_FRAC-1:0] decay_prod;
	logic [PHASE_W+MAP_FRAC-1:0] map_prod;
	logic [PHASE_W-1:0]          phase_next;
	logic [PCNT_W-1:0]           period_cnt_next;

	// Once the tail is over only the fast waveform plays
	assign fast_wave = !cycling || (period_cnt >= PCNT_W'(sound_pkg::SLOW_PERIODS));

	assign period_last = fast_wave ? PHASE_W'(sound_pkg::FAST_PERIOD - 1)
	                               : PHASE_W'(sound_pkg::SLOW_PERIOD - 1);
	assign high_len    = fast_wave ? PHASE_W'(sound_pkg::FAST_HIGH)
	                               : PHASE_W'(sound_pkg::SLOW_HIGH);

	always_comb begin
		if (phase < high_len) begin
			level = 2'd2;
		end else if (phase == high_len) begin
			level = 2'd1; // Single transition sample
		end else begin
			level = 2'd0;
		end
	end

	assign wave_prod  = amp * level;
	assign decay_prod = amp * sound_pkg::BONUS_DECAY;
	assign map_prod   = phase * MAP_RATIO;

	always_comb begin
		phase_next      = phase + 1'b1;
		period_cnt_next = period_cnt;
		if (phase == period_last) begin
			phase_next = '0;
			if (period_cnt == PCNT_W'(sound_pkg::CYCLE_PERIODS - 1)) begin
				period_cnt_next = '0;
			end else begin
				period_cnt_next = period_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			amp          <= '0;
			phase        <= '0;
			period_cnt   <= '0;
			tail_cnt     <= '0;
			cycling      <= 1'b0;
			bonus_sample <= '0;
		end else if (sample_tick) begin
			bonus_sample <= wave_prod[sound_pkg::AMP_FRAC +: sound_pkg::SAMPLE_W];
			if (bonus_en) begin
				amp      <= sound_pkg::AMP_MAX;
				tail_cnt <= '0;
				cycling  <= 1'b1;
				if (cycling) begin
					phase      <= phase_next;
					period_cnt <= period_cnt_next;
				end else begin
					phase      <= '0; // Fresh start from the fast-only phase
					period_cnt <= '0;
				end
			end else begin
				amp <= decay_prod[sound_pkg::AMP_FRAC +: sound_pkg::AMP_W];
				if (!cycling) begin
					phase <= phase_next;
				end else if (tail_cnt == TAIL_W'(TAIL_LEN - 1)) begin
					// Slow phase moves to the same relative point in the fast period
					cycling <= 1'b0;
					phase   <= fast_wave ? phase_next : map_prod[MAP_FRAC +: PHASE_W];
				end else begin
					tail_cnt   <= tail_cnt + 1'b1;
					phase      <= phase_next;
					period_cnt <= period_cnt_next;
				end
			end
		end
	end

	assign bonus_busy = (amp != '0);

endmodule

// ==== src/sound_crash_voice.sv ====
`timescale 1ns/1ps

module sound_crash_voice (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            sample_tick,
	input  logic                            crash_trig,
	output logic [sound_pkg::SAMPLE_W-1:0]  crash_sample,
	output logic                            crash_busy
);
	logic [sound_pkg::AMP_W-1:0] amp;
	logic [15:0]                 lfsr;
	logic                        trig_pending;
	logic                        start;
	logic                        feedback;
	logic [sound_pkg::AMP_W+sound_pkg::AMP_FRAC-1:0] decay_prod;

	// A trigger in the tick cycle itself is applied right away
	assign start = trig_pending || crash_trig;

	// Taps 16, 14, 13 and 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	assign decay_prod = amp * sound_pkg::CRASH_DECAY;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			trig_pending <= 1'b0;
		end else if (sample_tick) begin
			trig_pending <= 1'b0;
		end else if (crash_trig) begin
			trig_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= sound_pkg::CRASH_SEED;
		end else if (sample_tick) begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			amp <= '0;
		end else if (sample_tick) begin
			if (start) begin
				amp <= sound_pkg::AMP_MAX;
			end else begin
				amp <= decay_prod[sound_pkg::AMP_FRAC +: sound_pkg::AMP_W];
			end
		end
	end

	// Same full scale as the bonus voice at level 2, so amp is taken one bit higher
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			crash_sample <= '0;
		end else if (sample_tick) begin
			if (lfsr[0]) begin
				crash_sample <= amp[sound_pkg::AMP_FRAC-1 +: sound_pkg::SAMPLE_W];
			end else begin
				crash_sample <= '0;
			end
		end
	end

	assign crash_busy = (amp != '0);

endmodule

// ==== src/sound_output_stage.sv ====
`timescale 1ns/1ps

module sound_output_stage #(
	parameter int CLK_DIV = 1042
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [sound_pkg::SAMPLE_W-1:0]  bonus_sample,
	input  logic [sound_pkg::SAMPLE_W-1:0]  crash_sample,
	input  logic [7:0]                      bonus_gain,
	input  logic [7:0]                      crash_gain,
	output logic                            sample_tick,
	output logic [sound_pkg::SAMPLE_W-1:0]  pcm_out,
	output logic                            pcm_valid
);
	localparam int DIV_W  = $clog2(CLK_DIV);
	localparam int PROD_W = sound_pkg::SAMPLE_W + 8;

	logic [DIV_W-1:0]              div_cnt;
	logic                          tick_d;
	logic [PROD_W-1:0]             bonus_prod;
	logic [PROD_W-1:0]             crash_prod;
	logic [sound_pkg::SAMPLE_W:0]  mix_sum;
	logic [sound_pkg::SAMPLE_W-1:0] mix_sat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign sample_tick = (div_cnt == DIV_W'(CLK_DIV - 1));

	// Gain is 8-bit unsigned, 0xFF is just under unity
	assign bonus_prod = bonus_sample * bonus_gain;
	assign crash_prod = crash_sample * crash_gain;

	assign mix_sum = bonus_prod[8 +: sound_pkg::SAMPLE_W] + crash_prod[8 +: sound_pkg::SAMPLE_W];
	assign mix_sat = mix_sum[sound_pkg::SAMPLE_W] ? '1 : mix_sum[sound_pkg::SAMPLE_W-1:0];

	// Voices register on the tick, so the mix is taken one cycle later
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tick_d    <= 1'b0;
			pcm_valid <= 1'b0;
			pcm_out   <= '0;
		end else begin
			tick_d    <= sample_tick;
			pcm_valid <= tick_d;
			if (tick_d) begin
				pcm_out <= mix_sat;
			end
		end
	end

endmodule

// ==== src/sound_pkg.sv ====
package sound_pkg;

	localparam int SAMPLE_W = 16;

	// Envelope amplitude in fixed point with AMP_FRAC fraction bits
	localparam int AMP_FRAC = 18;
	localparam int AMP_W    = 34;

	// Level 2 at this amplitude gives 0xFFFF after the fraction shift
	localparam logic [AMP_W-1:0] AMP_MAX = {1'b0, {(AMP_W-1){1'b1}}};

	// Half the amplitude in about 28 ms at a 48 kHz sample rate
	localparam logic [AMP_FRAC-1:0] BONUS_DECAY = 18'd262008;
	// The crash dies out much faster than the bonus tone
	localparam logic [AMP_FRAC-1:0] CRASH_DECAY = 18'd261100;

	localparam int SLOW_PERIOD = 132;
	localparam int FAST_PERIOD = 79;
	localparam int SLOW_HIGH   = 97;
	localparam int FAST_HIGH   = 57;

	// Counted in whole periods of the current waveform
	localparam int SLOW_PERIODS  = 55;
	localparam int CYCLE_PERIODS = 75;

	// Counted in slow-period lengths after bonus_en drops
	localparam int TAIL_PERIODS = 11;

	localparam int ADDR_W = 4;

	localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_VOLUME = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h8;

	localparam logic [15:0] CRASH_SEED = 16'hace1;

endpackage

// ==== src/sound_top.sv ====
`timescale 1ns/1ps

module sound_top #(
	parameter int CLK_DIV = 1042 // 50 MHz down to about 48 kHz
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [sound_pkg::ADDR_W-1:0]    paddr,
	input  logic [31:0]                     pwdata,
	output logic [31:0]                     prdata,
	output logic                            pslverr,
	output logic [sound_pkg::SAMPLE_W-1:0]  pcm_out,
	output logic                            pcm_valid
);
	logic                           sample_tick;
	logic                           bonus_en;
	logic                           crash_trig;
	logic [7:0]                     bonus_gain;
	logic [7:0]                     crash_gain;
	logic                           bonus_busy;
	logic                           crash_busy;
	logic [sound_pkg::SAMPLE_W-1:0] bonus_sample;
	logic [sound_pkg::SAMPLE_W-1:0] crash_sample;

	sound_apb_regs sound_apb_regs_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pslverr    (pslverr),
		.bonus_busy (bonus_busy),
		.crash_busy (crash_busy),
		.bonus_en   (bonus_en),
		.crash_trig (crash_trig),
		.bonus_gain (bonus_gain),
		.crash_gain (crash_gain)
	);

	sound_bonus_voice sound_bonus_voice_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.sample_tick  (sample_tick),
		.bonus_en     (bonus_en),
		.bonus_sample (bonus_sample),
		.bonus_busy   (bonus_busy)
	);

	sound_crash_voice sound_crash_voice_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.sample_tick  (sample_tick),
		.crash_trig   (crash_trig),
		.crash_sample (crash_sample),
		.crash_busy   (crash_busy)
	);

	sound_output_stage #(
		.CLK_DIV (CLK_DIV)
	) sound_output_stage_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.bonus_sample (bonus_sample),
		.crash_sample (crash_sample),
		.bonus_gain   (bonus_gain),
		.crash_gain   (crash_gain),
		.sample_tick  (sample_tick),
		.pcm_out      (pcm_out),
		.pcm_valid    (pcm_valid)
	);

endmodule

// ==== verif/sound_props.sv ====
`timescale 1ns/1ps

module sound_props #(
	parameter int CLK_DIV = 8
) (
	input logic        clk,
	input logic        arst_n,
	input logic        psel,
	input logic        penable,
	input logic [31:0] prdata,
	input logic        pslverr,
	input logic [15:0] pcm_out,
	input logic        pcm_valid
);
	logic [15:0] gap; // Cycles since the last pcm_valid
	logic        seen;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gap  <= '0;
			seen <= 1'b0;
		end else if (pcm_valid) begin
			gap  <= '0;
			seen <= 1'b1;
		end else begin
			gap <= gap + 1'b1;
		end
	end

	valid_single: assert property (@(posedge clk) disable iff (!arst_n)
		pcm_valid |=> !pcm_valid) else $error("pcm_valid stayed high for more than one cycle");

	valid_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		pcm_valid && seen |-> gap == 16'(CLK_DIV - 1)) else $error("pcm_valid came too early");

	valid_not_late: assert property (@(posedge clk) disable iff (!arst_n)
		seen |-> gap < 16'(CLK_DIV)) else $error("pcm_valid came too late");

	pcm_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!$stable(pcm_out) |-> pcm_valid) else $error("pcm_out changed without pcm_valid");

	prdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
		penable && $past(penable) |-> $stable(prdata)) else $error("prdata moved during access");

	// Read data and error are only driven in the access cycle
	idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!(psel && penable) |-> prdata == '0 && !pslverr) else $error("APB outputs busy when idle");

endmodule

bind sound_top sound_props #(
	.CLK_DIV (CLK_DIV)
) sound_props_inst (
	.clk       (clk),
	.arst_n    (arst_n),
	.psel      (psel),
	.penable   (penable),
	.prdata    (prdata),
	.pslverr   (pslverr),
	.pcm_out   (pcm_out),
	.pcm_valid (pcm_valid)
);

// ==== verif/sound_tb.sv ====
`timescale 1ns/1ps

module sound_tb;
	localparam int CLK_DIV  = 8;
	localparam int TAIL_LEN = sound_pkg::TAIL_PERIODS * sound_pkg::SLOW_PERIOD;
	localparam int TONE_LEN = sound_pkg::SLOW_PERIODS * sound_pkg::SLOW_PERIOD +
		(sound_pkg::CYCLE_PERIODS - sound_pkg::SLOW_PERIODS) * sound_pkg::FAST_PERIOD;

	logic        clk = 1'b0;
	logic        arst_n = 1'b0;
	logic        psel = 1'b0;
	logic        penable = 1'b0;
	logic        pwrite = 1'b0;
	logic [3:0]  paddr = '0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic        pslverr;
	logic [15:0] pcm_out;
	logic        pcm_valid;

	logic [31:0] rng_state = 32'h0f13fa6f;
	logic        sh_en = 1'b0; // Register values as the DUT holds them this cycle
	logic [7:0]  sh_bgain = '0;
	logic [7:0]  sh_cgain = '0;
	int          trig_cnt = 0;
	int          trig_seen = 0;
	logic [2:0]  en_hist = '0;
	logic [2:0]  trig_hist = '0;
	logic        trig_acc = 1'b0;
	logic [7:0]  bgain_prev = '0;
	logic [7:0]  cgain_prev = '0;
	int          sat_seen = 0;

	logic [63:0] b_amp = '0;
	int          b_phase = 0;
	int          b_pcnt = 0;
	int          b_tail = 0;
	logic        b_cyc = 1'b0;
	logic [63:0] c_amp = '0;
	logic [15:0] c_lfsr = sound_pkg::CRASH_SEED;

	sound_top #(
		.CLK_DIV (CLK_DIV)
	) sound_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.pcm_out   (pcm_out),
		.pcm_valid (pcm_valid)
	);

	always #2 clk = ~clk;

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			rng_state = {1'b0, rng_state[31:1]} ^ (rng_state[0] ? 32'h80200003 : 32'h0);
			v = {v[30:0], rng_state[0]};
		end
		return v;
	endfunction

	// One audio sample of both voices, the gains and the saturating mix
	task automatic step_model(input logic en, input logic start, output logic [15:0] pcm);
		logic        fast;
		int          last;
		int          high;
		int          level;
		int          nphase;
		int          npcnt;
		logic [63:0] b_smp;
		logic [63:0] c_smp;
		logic [63:0] mix;
		fast   = !b_cyc || (b_pcnt >= sound_pkg::SLOW_PERIODS);
		last   = fast ? sound_pkg::FAST_PERIOD - 1 : sound_pkg::SLOW_PERIOD - 1;
		high   = fast ? sound_pkg::FAST_HIGH : sound_pkg::SLOW_HIGH;
		level  = (b_phase < high) ? 2 : ((b_phase == high) ? 1 : 0);
		b_smp  = ((b_amp * 64'(level)) >> sound_pkg::AMP_FRAC) & 64'hffff;
		nphase = (b_phase == last) ? 0 : b_phase + 1;
		npcnt  = (b_phase == last) ? (b_pcnt + 1) % sound_pkg::CYCLE_PERIODS : b_pcnt;
		if (en) begin
			b_amp   = 64'(sound_pkg::AMP_MAX);
			b_phase = b_cyc ? nphase : 0; // A new start begins with the slow tone
			b_pcnt  = b_cyc ? npcnt : 0;
			b_tail  = 0;
			b_cyc   = 1'b1;
		end else begin
			b_amp = (b_amp * 64'(sound_pkg::BONUS_DECAY)) >> sound_pkg::AMP_FRAC;
			if (!b_cyc) begin
				b_phase = nphase;
			end else if (b_tail == TAIL_LEN - 1) begin
				b_cyc   = 1'b0;
				b_phase = fast ? nphase : (b_phase * sound_pkg::FAST_PERIOD) / sound_pkg::SLOW_PERIOD;
			end else begin
				b_tail++;
				b_phase = nphase;
				b_pcnt  = npcnt;
			end
		end
		c_smp  = c_lfsr[0] ? ((c_amp >> (sound_pkg::AMP_FRAC - 1)) & 64'hffff) : 64'd0;
		c_lfsr = {c_lfsr[14:0], c_lfsr[15] ^ c_lfsr[13] ^ c_lfsr[12] ^ c_lfsr[10]};
		c_amp  = start ? 64'(sound_pkg::AMP_MAX)
		               : (c_amp * 64'(sound_pkg::CRASH_DECAY)) >> sound_pkg::AMP_FRAC;
		mix = ((b_smp * 64'(bgain_prev)) >> 8) + ((c_smp * 64'(cgain_prev)) >> 8);
		pcm = (mix > 64'hffff) ? 16'hffff : mix[15:0];
	endtask

	// Controls reach the voices in the tick cycle, two cycles before pcm_valid
	always @(negedge clk) begin
		logic [15:0] expect_pcm;
		en_hist   = {en_hist[1:0], sh_en};
		trig_hist = {trig_hist[1:0], trig_cnt != trig_seen};
		trig_seen = trig_cnt;
		if (pcm_valid) begin
			step_model(en_hist[2], trig_acc | trig_hist[2], expect_pcm);
			trig_acc = 1'b0;
			assert (pcm_out === expect_pcm) else report_error($sformatf(
				"** Error pcm_out: got 0x%04h, expected 0x%04h", pcm_out, expect_pcm));
			if (pcm_out == 16'hffff) begin
				sat_seen++;
			end
		end else begin
			trig_acc = trig_acc | trig_hist[2]; // Latched until the next tick
		end
		bgain_prev = sh_bgain;
		cgain_prev = sh_cgain;
	end

	task automatic wait_sample();
		int n;
		n = 0;
		@(negedge clk);
		while (!pcm_valid) begin
			n++;
			if (n > 4 * CLK_DIV) begin
				report_error("Timed out waiting for pcm_valid");
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_samples(input int count);
		repeat (count) wait_sample();
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
	                        output logic [31:0] rdata);
		logic err;
		logic exp_err;
		exp_err = !(addr == sound_pkg::ADDR_CTRL || addr == sound_pkg::ADDR_VOLUME ||
			addr == sound_pkg::ADDR_STATUS) || (wr && addr == sound_pkg::ADDR_STATUS);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		assert (err === exp_err) else report_error($sformatf(
			"** Error pslverr: got 0x%0h, expected 0x%0h at address 0x%0h", err, exp_err, addr));
		if (wr && !err) begin
			if (addr == sound_pkg::ADDR_CTRL) begin
				sh_en = wdata[0];
				if (wdata[1]) begin
					trig_cnt++;
				end
			end else if (addr == sound_pkg::ADDR_VOLUME) begin
				sh_bgain = wdata[7:0];
				sh_cgain = wdata[15:8];
			end
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		apb_xfer(1'b1, addr, data, rdata);
	endtask

	task automatic check_read(input logic [3:0] addr);
		logic [31:0] rdata;
		logic [31:0] expect_val;
		if (addr == sound_pkg::ADDR_STATUS) begin
			wait_sample(); // Read between ticks so the busy flags are settled
		end
		apb_xfer(1'b0, addr, '0, rdata);
		case (addr)
			sound_pkg::ADDR_CTRL:   expect_val = {31'd0, sh_en};
			sound_pkg::ADDR_VOLUME: expect_val = {16'd0, sh_cgain, sh_bgain};
			default:                expect_val = {30'd0, c_amp != 0, b_amp != 0};
		endcase
		assert (rdata === expect_val) else report_error($sformatf(
			"** Error prdata: got 0x%08h, expected 0x%08h at address 0x%0h", rdata, expect_val, addr));
	endtask

	task automatic poke_unmapped();
		logic [31:0] rdata;
		logic [3:0]  addr;
		logic        wr;
		addr = 4'(rand_bits(4));
		wr   = rand_bits(1) != 0;
		if (addr == 4'h0 || addr == 4'h4 || addr == 4'h8) begin
			addr = addr | 4'h1;
		end
		apb_xfer(wr, addr, rand_bits(32), rdata);
	endtask

	initial begin
		int loops;
		int sat_before;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		write_reg(sound_pkg::ADDR_VOLUME, rand_bits(16));
		check_read(sound_pkg::ADDR_VOLUME);
		write_reg(sound_pkg::ADDR_CTRL, 32'h2);
		check_read(sound_pkg::ADDR_CTRL);
		write_reg(sound_pkg::ADDR_STATUS, 32'h3);
		repeat (4) poke_unmapped();
		check_read(sound_pkg::ADDR_STATUS);

		// Full slow and fast cycle, then into the next one
		write_reg(sound_pkg::ADDR_VOLUME, 32'h00ff);
		write_reg(sound_pkg::ADDR_CTRL, 32'h1);
		check_read(sound_pkg::ADDR_CTRL);
		wait_samples(TONE_LEN + 400);
		check_read(sound_pkg::ADDR_STATUS);

		write_reg(sound_pkg::ADDR_CTRL, 32'h0);
		loops = 0;
		while (b_amp != 0) begin
			wait_samples(256);
			check_read(sound_pkg::ADDR_STATUS);
			loops++;
			if (loops > 200) begin
				report_error("Bonus voice never went idle after bonus_en dropped");
			end
		end
		check_read(sound_pkg::ADDR_STATUS);

		write_reg(sound_pkg::ADDR_VOLUME, 32'hff00);
		write_reg(sound_pkg::ADDR_CTRL, 32'h2);
		check_read(sound_pkg::ADDR_STATUS);
		// The trigger may still wait for its tick, so the decay is followed at least once
		loops = 0;
		do begin
			wait_samples(64);
			check_read(sound_pkg::ADDR_STATUS);
			loops++;
			if (loops > 200) begin
				report_error("Crash voice never went idle after its trigger");
			end
		end while (c_amp != 0);

		for (int i = 0; i < 32; i++) begin
			write_reg(sound_pkg::ADDR_VOLUME, rand_bits(16));
			write_reg(sound_pkg::ADDR_CTRL, rand_bits(2));
			if (rand_bits(1) != 0) begin
				poke_unmapped();
			end
			wait_samples(1 + rand_bits(8));
			check_read(sound_pkg::ADDR_STATUS);
		end

		sat_before = sat_seen;
		write_reg(sound_pkg::ADDR_VOLUME, 32'hffff);
		write_reg(sound_pkg::ADDR_CTRL, 32'h3);
		wait_samples(64);
		if (sat_seen > sat_before) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			report_error("pcm_out never clamped with both gains at full scale");
		end
	end

endmodule
